// File: build.f
hdl/dds_pkg.sv
hdl/modem_pkg.sv
hdl/dds_cfg_if.sv
hdl/dds_config.sv
hdl/wave_gen.sv
hdl/pn_symbol_source.sv
hdl/modulator.sv
hdl/dds_lab_top.sv
tests/dds_lab_checker.sv
tests/dds_lab_tb.sv

// File: hdl/sine_table.hex
// offset-binary 12-bit sine, one sample per line, table index 0 to 63
800
8C9
98F
A52
B0F
BC5
C71
D13
DA7
E2E
EA6
F0D
F63
FA7
FD8
FF5
FFF
FF5
FD8
FA7
F63
F0D
EA6
E2E
DA7
D13
C71
BC5
B0F
A52
98F
8C9
800
737
671
5AE
4F1
43B
38F
2ED
259
1D2
15A
0F3
09D
059
028
00B
001
00B
028
059
09D
0F3
15A
1D2
259
2ED
38F
43B
4F1
5AE
671
737

// File: tests/dds_lab_tb.sv
`default_nettype none

module dds_lab_tb
   import dds_pkg::*, modem_pkg::*;
();

   localparam int clk_period    = 100;
   localparam int drive_delay   = 10;
   localparam int reset_cycles  = 16;
   localparam int idle_cycles   = 200;
   localparam int sweep_cycles  = 256;   // about five table turns
   localparam int select_cycles = 150;
   localparam int short_period  = 6;
   localparam int pn_symbols    = 31;
   localparam int keyed_cycles  = 80;
   localparam int misc_cycles   = 80;
   localparam int margin_cycles = 500;
   // every phase of the run plus the symbols at their programmed periods
   localparam int watchdog_cycles = reset_cycles + idle_cycles + sweep_cycles
      + 3 * select_cycles + 4 * keyed_cycles + 2 * misc_cycles
      + int'(symbol_period_reset) + (pn_symbols + 2) * short_period + margin_cycles;

   typedef struct packed {
      logic [31:0] carrier_inc;
      logic [31:0] mark_inc;
      logic [31:0] space_inc;
      logic [31:0] symbol_period;
      sig_sel_t    sig_sel;
      mod_sel_t    mod_sel;
      logic [31:0] phase;
      sample_t     sin_s;
      sample_t     cos_s;
      sample_t     saw_s;
      sample_t     squ_s;
      logic [31:0] fsk_phase;
      sample_t     fsk_cos;
      logic [31:0] count;
      logic        tick;
      logic [4:0]  lfsr;
      sample_t     wave_out;
      sample_t     mod_out;
   } model_t;

   logic        clk;
   logic        reset;
   logic        cfg_write;
   cfg_addr_t   cfg_addr;
   logic [31:0] cfg_data;
   sample_t     wave_out;
   sample_t     mod_out;
   logic        pn_bit;
   logic        symbol_tick;
   sample_t     sine_ref [64];
   model_t      model;
   logic        model_live;
   integer      seed;

   dds_lab_top i_dds_lab_top (
      .clk         (clk),
      .reset       (reset),
      .cfg_write   (cfg_write),
      .cfg_addr    (cfg_addr),
      .cfg_data    (cfg_data),
      .wave_out    (wave_out),
      .mod_out     (mod_out),
      .pn_bit      (pn_bit),
      .symbol_tick (symbol_tick)
   );

   initial
   begin
      $readmemh("hdl/sine_table.hex", sine_ref);
   end

   always #(clk_period / 2) clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////////////////////////

   function automatic model_t next_state(model_t s, logic rst, logic wr, cfg_addr_t addr,
                                         logic [31:0] data);
      model_t     n;
      logic       pn;
      logic [5:0] cidx;
      logic [5:0] fidx;
      n    = s;
      pn   = s.lfsr[0];
      cidx = s.phase[31:26] + 6'd16;       // quarter turn ahead
      fidx = s.fsk_phase[31:26] + 6'd16;
      if (rst)
      begin
         n               = '0;
         n.carrier_inc   = carrier_inc_reset;
         n.mark_inc      = mark_inc_reset;
         n.space_inc     = space_inc_reset;
         n.symbol_period = symbol_period_reset;
         n.lfsr          = 5'b11111;
      end
      else
      begin
         if (wr)
         begin
            case (addr)
               reg_carrier_inc:   n.carrier_inc = data;
               reg_mark_inc:      n.mark_inc = data;
               reg_space_inc:     n.space_inc = data;
               reg_symbol_period: n.symbol_period = data;
               reg_select:
               begin
                  n.sig_sel = data[1:0];
                  n.mod_sel = data[3:2];
               end
               default:
               begin
                  // unmapped, nothing stored
               end
            endcase
         end
         // samples come from the phase held before the edge
         n.phase     = s.phase + s.carrier_inc;
         n.sin_s     = sine_ref[s.phase[31:26]];
         n.cos_s     = sine_ref[cidx];
         n.saw_s     = s.phase[31:20];
         n.squ_s     = s.phase[31] ? 12'h000 : 12'hfff;
         n.fsk_phase = s.fsk_phase + (pn ? s.mark_inc : s.space_inc);
         n.fsk_cos   = sine_ref[fidx];
         n.tick      = (s.count >= s.symbol_period - 32'd1);
         if (n.tick)
         begin
            n.count = '0;
            n.lfsr  = {s.lfsr[0] ^ s.lfsr[2], s.lfsr[4:1]};
         end
         else
         begin
            n.count = s.count + 32'd1;
         end
         case (s.sig_sel)
            sig_sine:   n.wave_out = s.sin_s;
            sig_cosine: n.wave_out = s.cos_s;
            sig_saw:    n.wave_out = s.saw_s;
            default:    n.wave_out = s.squ_s;
         endcase
         case (s.mod_sel)
            mod_ask:  n.mod_out = pn ? s.cos_s : 12'h800;
            mod_fsk:  n.mod_out = s.fsk_cos;
            mod_bpsk: n.mod_out = pn ? s.cos_s : 12'hfff - s.cos_s;
            default:  n.mod_out = pn ? 12'hfff : 12'h000;
         endcase
      end
      return n;
   endfunction

   always @(posedge clk)
   begin
      model      = next_state(model, reset, cfg_write, cfg_addr, cfg_data);
      model_live = 1'b1;
   end

   //////////////////////////////////////////////////////////////////////
   // comparison, midway between edges
   //////////////////////////////////////////////////////////////////////

   task automatic stop_on_failure();
      $display("Test failures found");
      $fatal(1, "simulation stopped after the first failure");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("MISMATCH %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
         stop_on_failure();
      end
   endtask

   always @(negedge clk)
   begin
      if (i_dds_lab_top.i_dds_lab_checker.failure_count != 0)
      begin
         $display("ERROR a concurrent assertion failed at %0t", $time);
         stop_on_failure();
      end
      if (model_live)
      begin
         check_value("wave_out", wave_out, model.wave_out);
         check_value("mod_out", mod_out, model.mod_out);
         check_value("pn_bit", pn_bit, model.lfsr[0]);
         check_value("symbol_tick", symbol_tick, model.tick);
      end
   end

   //////////////////////////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////////////////////////

   task automatic run_cycles(input int n);
      repeat (n)
      begin
         @(posedge clk);
         #drive_delay;
      end
   endtask

   // called just after an edge, returns just after the next one
   task automatic write_reg(input cfg_addr_t addr, input logic [31:0] data);
      cfg_write = 1'b1;
      cfg_addr  = addr;
      cfg_data  = data;
      @(posedge clk);
      #drive_delay;
      cfg_write = 1'b0;
      cfg_data  = $random(seed);   // junk while idle
   endtask

   task automatic wait_for_tick();
      @(posedge clk);
      #drive_delay;
      while (symbol_tick !== 1'b1)
      begin
         @(posedge clk);
         #drive_delay;
      end
   endtask

   // one tick per period, and one full maximal-length sequence over 31 symbols
   task automatic check_pn_period();
      int ticks;
      int ones;
      ticks = 0;
      ones  = 0;
      wait_for_tick();
      repeat (pn_symbols * short_period)
      begin
         @(posedge clk);
         #drive_delay;
         if (symbol_tick)
         begin
            ticks++;
            if (pn_bit)
               ones++;
         end
      end
      check_value("symbol_tick count", ticks, pn_symbols);
      // every nonzero lfsr state once, 16 of them with bit 0 set
      check_value("pn_bit ones in 31 symbols", ones, (pn_symbols + 1) / 2);
   endtask

   initial
   begin
      int sel;
      int addr;
      seed       = 32'h570a_9cea;
      clk        = 1'b0;
      reset      = 1'b1;
      cfg_write  = 1'b0;
      cfg_addr   = '0;
      cfg_data   = '0;
      model_live = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      #drive_delay;
      reset = 1'b0;

      run_cycles(idle_cycles);   // default carrier
      write_reg(reg_carrier_inc, 32'h0530_0000);
      run_cycles(sweep_cycles);

      for (sel = 1; sel < 4; sel++)
      begin
         write_reg(reg_select, 32'(sel));
         run_cycles(select_cycles);
      end

      write_reg(reg_symbol_period, short_period);
      check_pn_period();

      write_reg(reg_select, {28'd0, mod_ask, sig_sine});
      run_cycles(keyed_cycles);
      write_reg(reg_select, {28'd0, mod_bpsk, sig_cosine});
      run_cycles(keyed_cycles);
      write_reg(reg_mark_inc, $random(seed));
      write_reg(reg_space_inc, $random(seed));
      write_reg(reg_select, {28'd0, mod_fsk, sig_saw});
      run_cycles(keyed_cycles);
      write_reg(reg_select, {28'd0, mod_raw, sig_square});
      run_cycles(keyed_cycles);

      // unmapped addresses, then a new carrier mid-run
      for (addr = 5; addr < 8; addr++)
         write_reg(cfg_addr_t'(addr), $random(seed));
      run_cycles(misc_cycles);
      write_reg(reg_carrier_inc, $random(seed));
      run_cycles(misc_cycles);

      if (i_dds_lab_top.i_dds_lab_checker.failure_count != 0)
      begin
         $display("ERROR %0d concurrent assertion failures during the run",
                  i_dds_lab_top.i_dds_lab_checker.failure_count);
         stop_on_failure();
      end
      else
      begin
         $display("All tests passed!");
         $finish;
      end
   end

   initial
   begin
      #(watchdog_cycles * clk_period);
      $display("ERROR watchdog expired after %0d cycles, the run hung", watchdog_cycles);
      stop_on_failure();
   end

endmodule

`default_nettype wire

// File: tests/dds_lab_checker.sv
`default_nettype none

module dds_lab_checker
   import dds_pkg::*, modem_pkg::*;
(
   input logic                clk,
   input logic                reset,
   input logic                symbol_tick,
   input logic                pn_bit,
   input sample_t             wave_out,
   input sample_t             mod_out,
   input logic [period_w-1:0] symbol_period
);

   int failure_count = 0;   // assertion failures so far

   // a tick restarts the count, back-to-back ticks only with a 1-cycle period
   tick_spacing: assert property (
      @(posedge clk) disable iff (reset)
      (symbol_tick && symbol_period > 1) |=> !symbol_tick
   )
   else
   begin
      $error("symbol_tick high on two consecutive cycles");
      failure_count++;
   end

   // registered outputs, so checked one edge after reset is seen
   outputs_in_reset: assert property (
      @(posedge clk)
      reset |=> (wave_out == '0 && mod_out == '0 && !symbol_tick && pn_bit == lfsr_seed[0])
   )
   else
   begin
      $error("outputs not at their reset values during reset");
      failure_count++;
   end

   pn_steps_on_tick: assert property (
      @(posedge clk) disable iff (reset)
      (pn_bit != $past(pn_bit)) |-> symbol_tick   // lfsr and tick share an edge
   )
   else
   begin
      $error("pn_bit changed without a symbol tick");
      failure_count++;
   end

endmodule

bind dds_lab_top dds_lab_checker i_dds_lab_checker (
   .clk           (clk),
   .reset         (reset),
   .symbol_tick   (symbol_tick),
   .pn_bit        (pn_bit),
   .wave_out      (wave_out),
   .mod_out       (mod_out),
   .symbol_period (cfg_bus.symbol_period)
);

`default_nettype wire

// File: hdl/dds_lab_top.sv
`default_nettype none

module dds_lab_top
   import dds_pkg::*, modem_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        cfg_write,      // one-cycle strobe
   input  cfg_addr_t   cfg_addr,
   input  logic [31:0] cfg_data,
   output sample_t     wave_out,
   output sample_t     mod_out,
   output logic        pn_bit,
   output logic        symbol_tick
);

   sample_t sin_w;
   sample_t cos_w;
   sample_t saw_w;
   sample_t squ_w;

   dds_cfg_if cfg_bus ();

   dds_config i_dds_config (
      .clk       (clk),
      .reset     (reset),
      .cfg_write (cfg_write),
      .cfg_addr  (cfg_addr),
      .cfg_data  (cfg_data),
      .cfg       (cfg_bus.source)
   );

   // carrier and its derived waves
   wave_gen i_wave_gen (
      .clk     (clk),
      .reset   (reset),
      .cfg     (cfg_bus.sink),
      .sin_out (sin_w),
      .cos_out (cos_w),
      .saw_out (saw_w),
      .squ_out (squ_w)
   );

   pn_symbol_source i_pn_symbol_source (
      .clk         (clk),
      .reset       (reset),
      .cfg         (cfg_bus.sink),
      .symbol_tick (symbol_tick),
      .pn_bit      (pn_bit)
   );

   modulator i_modulator (
      .clk      (clk),
      .reset    (reset),
      .cfg      (cfg_bus.sink),
      .sin_in   (sin_w),
      .cos_in   (cos_w),
      .saw_in   (saw_w),
      .squ_in   (squ_w),
      .pn_bit   (pn_bit),
      .wave_out (wave_out),
      .mod_out  (mod_out)
   );

endmodule

`default_nettype wire

// File: hdl/modulator.sv
`default_nettype none

module modulator
   import dds_pkg::*, modem_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   dds_cfg_if.sink   cfg,
   input  sample_t   sin_in,
   input  sample_t   cos_in,
   input  sample_t   saw_in,
   input  sample_t   squ_in,
   input  logic      pn_bit,
   output sample_t   wave_out,
   output sample_t   mod_out
);

   sample_t            sine_rom [table_depth];
   phase_word_u        fsk_phase;
   logic [index_w-1:0] fsk_index;
   sample_t            fsk_cos;
   sample_t            ask_wave;
   sample_t            bpsk_wave;
   sample_t            raw_wave;
   sample_t            sel_wave;
   sample_t            keyed_wave;

   initial
   begin
      $readmemh(sine_table_file, sine_rom);
   end

   //////////////////////////////////////////////////////////////////////
   // fsk channel
   //////////////////////////////////////////////////////////////////////

   assign fsk_index = fsk_phase.fields.index + quarter_turn;   // cosine tap

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         fsk_phase.raw <= '0;
         fsk_cos       <= '0;
      end
      else
      begin
         fsk_phase.raw <= fsk_phase.raw + (pn_bit ? cfg.mark_inc : cfg.space_inc);
         fsk_cos       <= sine_rom[fsk_index];
      end
   end

   // keyed versions of the carrier cosine
   assign ask_wave  = pn_bit ? cos_in : sample_mid;
   assign bpsk_wave = pn_bit ? cos_in : sample_max - cos_in;   // mirror about midscale
   assign raw_wave  = {sample_w{pn_bit}};

   always_comb
   begin
      case (cfg.sig_sel)
         sig_sine:   sel_wave = sin_in;
         sig_cosine: sel_wave = cos_in;
         sig_saw:    sel_wave = saw_in;
         sig_square: sel_wave = squ_in;
         default:    sel_wave = sin_in;
      endcase
      case (cfg.mod_sel)
         mod_ask:  keyed_wave = ask_wave;
         mod_fsk:  keyed_wave = fsk_cos;
         mod_bpsk: keyed_wave = bpsk_wave;
         mod_raw:  keyed_wave = raw_wave;
         default:  keyed_wave = ask_wave;
      endcase
   end

   // output stage
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wave_out <= '0;
         mod_out  <= '0;
      end
      else
      begin
         wave_out <= sel_wave;
         mod_out  <= keyed_wave;
      end
   end

endmodule

`default_nettype wire

// File: hdl/pn_symbol_source.sv
`default_nettype none

module pn_symbol_source
   import modem_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   dds_cfg_if.sink   cfg,
   output logic      symbol_tick,
   output logic      pn_bit
);

   logic [period_w-1:0] count;
   logic [lfsr_w-1:0]   lfsr;
   logic                last_count;

   // >= so a shortened period never lets the count run past it
   assign last_count = (count >= cfg.symbol_period - 1'b1);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         count       <= '0;
         symbol_tick <= 1'b0;
         lfsr        <= lfsr_seed;
      end
      else
      begin
         symbol_tick <= last_count;
         if (last_count)
         begin
            count <= '0;
            // shift toward bit 0, feedback into the top
            lfsr  <= {lfsr[0] ^ lfsr[lfsr_tap], lfsr[lfsr_w-1:1]};
         end
         else
         begin
            count <= count + 1'b1;
         end
      end
   end

   assign pn_bit = lfsr[0];

endmodule

`default_nettype wire

// File: hdl/wave_gen.sv
`default_nettype none

module wave_gen
   import dds_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   dds_cfg_if.sink   cfg,
   output sample_t   sin_out,
   output sample_t   cos_out,
   output sample_t   saw_out,
   output sample_t   squ_out
);

   sample_t            sine_rom [table_depth];
   phase_word_u        phase;
   logic [index_w-1:0] cos_index;

   initial
   begin
      $readmemh(sine_table_file, sine_rom);
   end

   // wraps modulo 64 through the index width
   assign cos_index = phase.fields.index + quarter_turn;

   //////////////////////////////////////////////////////////////////////
   // carrier phase accumulator
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
         phase.raw <= '0;
      else
         phase.raw <= phase.raw + cfg.carrier_inc;   // new increment applies at once
   end

   //////////////////////////////////////////////////////////////////////
   // sample registers, one cycle behind the phase
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         sin_out <= '0;
         cos_out <= '0;
         saw_out <= '0;
         squ_out <= '0;
      end
      else
      begin
         sin_out <= sine_rom[phase.fields.index];
         cos_out <= sine_rom[cos_index];
         saw_out <= phase.raw[phase_w-1 -: sample_w];   // ramp from the top bits
         // high for the first half turn
         squ_out <= phase.raw[phase_w-1] ? sample_t'(0) : sample_max;
      end
   end

endmodule

`default_nettype wire

// File: hdl/dds_config.sv
`default_nettype none

module dds_config
   import dds_pkg::*, modem_pkg::*;
(
   input  logic             clk,
   input  logic             reset,
   input  logic             cfg_write,
   input  cfg_addr_t        cfg_addr,
   input  logic [31:0]      cfg_data,
   dds_cfg_if.source        cfg
);

   //////////////////////////////////////////////////////////////////////
   // host write port, value visible the cycle after the strobe
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         cfg.carrier_inc   <= carrier_inc_reset;
         cfg.mark_inc      <= mark_inc_reset;
         cfg.space_inc     <= space_inc_reset;
         cfg.symbol_period <= symbol_period_reset;
         cfg.sig_sel       <= sig_sine;
         cfg.mod_sel       <= mod_ask;
      end
      else if (cfg_write)
      begin
         case (cfg_addr)
            reg_carrier_inc:   cfg.carrier_inc   <= cfg_data;
            reg_mark_inc:      cfg.mark_inc      <= cfg_data;
            reg_space_inc:     cfg.space_inc     <= cfg_data;
            reg_symbol_period: cfg.symbol_period <= cfg_data;
            reg_select:
            begin
               cfg.sig_sel <= cfg_data[1:0];
               cfg.mod_sel <= cfg_data[3:2];   // upper bits not stored
            end
            default:
            begin
               // addresses 5 to 7 unmapped
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hdl/dds_cfg_if.sv
`default_nettype none

interface dds_cfg_if
   import dds_pkg::*, modem_pkg::*;
();

   logic [phase_w-1:0]  carrier_inc;
   logic [phase_w-1:0]  mark_inc;     // fsk increment on 1-bits
   logic [phase_w-1:0]  space_inc;    // fsk increment on 0-bits
   logic [period_w-1:0] symbol_period;
   sig_sel_t            sig_sel;
   mod_sel_t            mod_sel;

   // register block side
   modport source (
      output carrier_inc, mark_inc, space_inc, symbol_period, sig_sel, mod_sel
   );

   // datapath side
   modport sink (
      input carrier_inc, mark_inc, space_inc, symbol_period, sig_sel, mod_sel
   );

endinterface

`default_nettype wire

// File: hdl/modem_pkg.sv
`default_nettype none

package modem_pkg;

   // wave selector
   typedef logic [1:0] sig_sel_t;
   localparam sig_sel_t sig_sine   = 2'd0;
   localparam sig_sel_t sig_cosine = 2'd1;
   localparam sig_sel_t sig_saw    = 2'd2;
   localparam sig_sel_t sig_square = 2'd3;

   // modulation selector
   typedef logic [1:0] mod_sel_t;
   localparam mod_sel_t mod_ask  = 2'd0;
   localparam mod_sel_t mod_fsk  = 2'd1;
   localparam mod_sel_t mod_bpsk = 2'd2;
   localparam mod_sel_t mod_raw  = 2'd3;

   // register map, reg_select packs sig_sel in 1:0 and mod_sel in 3:2
   typedef logic [2:0] cfg_addr_t;
   localparam cfg_addr_t reg_carrier_inc   = 3'd0;
   localparam cfg_addr_t reg_mark_inc      = 3'd1;
   localparam cfg_addr_t reg_space_inc     = 3'd2;
   localparam cfg_addr_t reg_symbol_period = 3'd3;
   localparam cfg_addr_t reg_select        = 3'd4;

   // pn generator, x^5 + x^2 + 1
   localparam int lfsr_w = 5;
   localparam logic [lfsr_w-1:0] lfsr_seed = 5'b11111;
   localparam int lfsr_tap = 2;   // xor-ed with bit 0

   localparam int period_w = 32;
   localparam logic [period_w-1:0] symbol_period_reset = 32'd40;   // clocks per symbol

endpackage

`default_nettype wire

// File: hdl/dds_pkg.sv
`default_nettype none

package dds_pkg;

   //////////////////////////////////////////////////////////////////////
   // sample and table geometry
   //////////////////////////////////////////////////////////////////////

   localparam int sample_w    = 12;
   localparam int phase_w     = 32;
   localparam int table_depth = 64;
   localparam int index_w     = 6;
   localparam int frac_w      = phase_w - index_w;

   // offset binary, midscale is zero
   typedef logic [sample_w-1:0] sample_t;

   localparam logic [index_w-1:0] quarter_turn = 6'd16;   // 90 degrees in table steps
   localparam sample_t sample_mid = 12'd2048;
   localparam sample_t sample_max = 12'd4095;

   // accumulator word, read raw or split into table index and fraction
   typedef union packed {
      logic [phase_w-1:0] raw;
      struct packed {
         logic [index_w-1:0] index;   // top bits address the sine table
         logic [frac_w-1:0]  frac;
      } fields;
   } phase_word_u;

   localparam string sine_table_file = "hdl/sine_table.hex";

   //////////////////////////////////////////////////////////////////////
   // power-up increments
   //////////////////////////////////////////////////////////////////////

   localparam logic [phase_w-1:0] carrier_inc_reset = 32'd258;
   localparam logic [phase_w-1:0] mark_inc_reset    = 32'd1032;   // 4x carrier
   localparam logic [phase_w-1:0] space_inc_reset   = 32'd516;    // 2x carrier

endpackage

`default_nettype wire
